/* source/io_pkg.sv */
`default_nettype none

package io_pkg;

	// one byte on the spi link
	typedef logic [7:0] io_byte_t;

	// joystick state: right, left, down, up, fire 1, fire 2
	typedef logic [5:0] joy_t;

	// buttons [1:0], switches [3:2], scandoubler off [4], ypbpr [5]
	typedef logic [5:0] cfg_t;

	// bit position inside the current byte
	typedef logic [2:0] bit_idx_t;

	// payload byte number, sticks at 15
	typedef logic [3:0] byte_idx_t;

	// framer position in a transfer
	typedef enum logic {
		PH_CMD,
		PH_PAYLOAD
	} frame_phase_e;

	// command codes from the io controller
	localparam io_byte_t CMD_CFG     = 8'h01;
	localparam io_byte_t CMD_KBD_IN  = 8'h02;
	localparam io_byte_t CMD_KBD_OUT = 8'h03;
	localparam io_byte_t CMD_SER_IN  = 8'h04;
	localparam io_byte_t CMD_SER_OUT = 8'h05;
	localparam io_byte_t CMD_JOY0    = 8'h10;
	localparam io_byte_t CMD_JOY1    = 8'h11;
	localparam io_byte_t CMD_JOY2    = 8'h12;
	localparam io_byte_t CMD_JOY3    = 8'h13;

	// returned during every command byte
	localparam io_byte_t CORE_TYPE = 8'hA4;

	// entries per core-to-host queue
	localparam int QUEUE_DEPTH = 4;

	// read and write position in a queue
	typedef logic [$clog2(QUEUE_DEPTH)-1:0] queue_ptr_t;

endpackage

`default_nettype wire

/* source/io_link_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface io_link_if;

	// byte framing events from the spi side
	logic cmd_done;
	logic byte_done;
	io_pkg::io_byte_t rx_byte;
	io_pkg::byte_idx_t byte_index;
	// first two bits of a payload byte
	logic early_payload;

	// reply byte for the current slot
	io_pkg::io_byte_t tx_byte;

	modport frame (
		output cmd_done,
		output byte_done,
		output rx_byte,
		output byte_index,
		output early_payload,
		input  tx_byte
	);

	modport decoder (
		input  cmd_done,
		input  byte_done,
		input  rx_byte,
		input  byte_index,
		input  early_payload,
		output tx_byte
	);

endinterface

`default_nettype wire

/* source/spi_frame.sv */
`timescale 1ns/1ns
`default_nettype none

module spi_frame (
	input  logic       spi_sck,
	input  logic       SPI_SS_IO,
	input  logic       spi_mosi,
	output logic       spi_miso,
	io_link_if.frame   link
);

	io_pkg::frame_phase_e phase;
	io_pkg::bit_idx_t     bit_cnt;
	io_pkg::byte_idx_t    byte_cnt;

	// bits 6..0 of the byte being received, newest bit at the bottom
	logic [6:0] sbuf;

	logic last_bit;

	assign last_bit = (bit_cnt == 3'd7);

	// bit counter, phase and payload byte count
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			phase    <= io_pkg::PH_CMD;
			bit_cnt  <= '0;
			byte_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (last_bit) begin
				if (phase == io_pkg::PH_CMD) begin
					phase <= io_pkg::PH_PAYLOAD;
				end else if (byte_cnt != 4'd15) begin
					byte_cnt <= byte_cnt + 4'd1;
				end
			end
		end
	end

	// shift register, cleared implicitly by the first eight bits
	always_ff @(posedge spi_sck) begin
		sbuf <= {sbuf[5:0], spi_mosi};
	end

	// the last bit is still on mosi, so the full byte is visible
	// before the edge that completes it
	assign link.rx_byte = {sbuf, spi_mosi};

	assign link.cmd_done  = last_bit && (phase == io_pkg::PH_CMD);
	assign link.byte_done = last_bit && (phase == io_pkg::PH_PAYLOAD);

	assign link.byte_index = byte_cnt;

	assign link.early_payload = (phase == io_pkg::PH_PAYLOAD) && (bit_cnt <= 3'd1);

	// reply goes out msb first; bit_cnt is 0 during reset, so the
	// first bit of the command slot is already set up when ss falls
	always_ff @(negedge spi_sck) begin
		spi_miso <= link.tx_byte[~bit_cnt];
	end

	// the two framing pulses belong to different phases
	a_done_exclusive: assert property (
		@(posedge spi_sck) disable iff (SPI_SS_IO)
		!(link.cmd_done && link.byte_done)
	) else $error("spi_frame: cmd_done and byte_done high together");

endmodule

`default_nettype wire

/* source/io_cmd_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module io_cmd_decoder (
	input  logic              spi_sck,
	input  logic              SPI_SS_IO,
	io_link_if.decoder        link,

	// core-to-host keyboard queue
	input  logic              kbd_avail,
	input  io_pkg::io_byte_t  kbd_head,
	output logic              kbd_pop,

	// core-to-host serial queue
	input  logic              ser_avail,
	input  io_pkg::io_byte_t  ser_head,
	output logic              ser_pop,

	// host-to-core data
	output logic              kbd_in_strobe,
	output io_pkg::io_byte_t  kbd_in_data,
	output logic              ser_in_strobe,
	output io_pkg::io_byte_t  ser_in_data,

	output io_pkg::cfg_t      cfg,
	output io_pkg::joy_t      joy0,
	output io_pkg::joy_t      joy1,
	output io_pkg::joy_t      joy2,
	output io_pkg::joy_t      joy3
);

	io_pkg::io_byte_t cmd;

	// high until the command byte of this transfer is in
	logic cmd_slot;

	// avail as sent in the even byte of the current read pair
	logic avail_q;

	// early_payload seen at the previous edge
	logic early_q;

	logic odd_byte;

	// payload registers keep their value across transfers
	io_pkg::io_byte_t kbd_data_q = '0;
	io_pkg::io_byte_t ser_data_q = '0;
	io_pkg::cfg_t     cfg_q      = '0;
	io_pkg::joy_t     joy0_q     = '0;
	io_pkg::joy_t     joy1_q     = '0;
	io_pkg::joy_t     joy2_q     = '0;
	io_pkg::joy_t     joy3_q     = '0;

	assign odd_byte = link.byte_index[0];

	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			cmd           <= '0;
			cmd_slot      <= 1'b1;
			avail_q       <= 1'b0;
			early_q       <= 1'b0;
			kbd_in_strobe <= 1'b0;
			ser_in_strobe <= 1'b0;
		end else begin
			early_q <= link.early_payload;

			if (link.cmd_done) begin
				cmd      <= link.rx_byte;
				cmd_slot <= 1'b0;
			end

			// strobes drop on the edge that completes bit 1 of the next byte
			if (link.early_payload && early_q) begin
				kbd_in_strobe <= 1'b0;
				ser_in_strobe <= 1'b0;
			end

			if (link.byte_done) begin
				if (cmd == io_pkg::CMD_KBD_IN)
					kbd_in_strobe <= 1'b1;
				if (cmd == io_pkg::CMD_SER_IN)
					ser_in_strobe <= 1'b1;

				if (!odd_byte) begin
					case (cmd)
						io_pkg::CMD_KBD_OUT: avail_q <= kbd_avail;
						io_pkg::CMD_SER_OUT: avail_q <= ser_avail;
						default:             avail_q <= 1'b0;
					endcase
				end
			end
		end
	end

	// payload capture, selected by the latched command
	always_ff @(posedge spi_sck) begin
		if (link.byte_done) begin
			case (cmd)
				io_pkg::CMD_CFG:    cfg_q      <= link.rx_byte[5:0];
				io_pkg::CMD_KBD_IN: kbd_data_q <= link.rx_byte;
				io_pkg::CMD_SER_IN: ser_data_q <= link.rx_byte;
				io_pkg::CMD_JOY0:   joy0_q     <= link.rx_byte[5:0];
				io_pkg::CMD_JOY1:   joy1_q     <= link.rx_byte[5:0];
				io_pkg::CMD_JOY2:   joy2_q     <= link.rx_byte[5:0];
				io_pkg::CMD_JOY3:   joy3_q     <= link.rx_byte[5:0];
				default: ;
			endcase
		end
	end

	assign kbd_in_data = kbd_data_q;
	assign ser_in_data = ser_data_q;
	assign cfg         = cfg_q;
	assign joy0        = joy0_q;
	assign joy1        = joy1_q;
	assign joy2        = joy2_q;
	assign joy3        = joy3_q;

	// pop at the end of the data byte, only if the host was told a byte was there
	assign kbd_pop = link.byte_done && odd_byte && avail_q &&
		(cmd == io_pkg::CMD_KBD_OUT);
	assign ser_pop = link.byte_done && odd_byte && avail_q &&
		(cmd == io_pkg::CMD_SER_OUT);

	// reply byte: core type first, then avail/data pairs for the read commands
	always_comb begin
		link.tx_byte = '0;
		if (cmd_slot) begin
			link.tx_byte = io_pkg::CORE_TYPE;
		end else begin
			case (cmd)
				io_pkg::CMD_KBD_OUT:
					link.tx_byte = odd_byte ? kbd_head : {7'd0, kbd_avail};
				io_pkg::CMD_SER_OUT:
					link.tx_byte = odd_byte ? ser_head : {7'd0, ser_avail};
				default:
					link.tx_byte = '0;
			endcase
		end
	end

	// the queues never see a pop while empty
	a_kbd_pop_nonempty: assert property (
		@(posedge spi_sck) disable iff (SPI_SS_IO)
		kbd_pop |-> kbd_avail
	) else $error("io_cmd_decoder: keyboard pop on empty queue");

	a_ser_pop_nonempty: assert property (
		@(posedge spi_sck) disable iff (SPI_SS_IO)
		ser_pop |-> ser_avail
	) else $error("io_cmd_decoder: serial pop on empty queue");

endmodule

`default_nettype wire

/* source/byte_queue.sv */
`timescale 1ns/1ns
`default_nettype none

module byte_queue (
	input  logic             spi_sck,
	input  logic             SPI_SS_IO,
	input  logic             push,
	input  io_pkg::io_byte_t push_data,
	input  logic             pop,
	output logic             avail,
	output io_pkg::io_byte_t head
);

	localparam int CNT_W = $clog2(io_pkg::QUEUE_DEPTH) + 1;

	io_pkg::io_byte_t mem [io_pkg::QUEUE_DEPTH];

	// the queue outlives transfers, so it starts empty once and stays live
	io_pkg::queue_ptr_t wr_ptr = '0;
	io_pkg::queue_ptr_t rd_ptr = '0;
	logic [CNT_W-1:0]   count  = '0;

	logic do_push;
	logic do_pop;

	// a push into a full queue is lost
	assign do_push = push && (count < io_pkg::QUEUE_DEPTH);
	assign do_pop  = pop && (count != '0);

	always_ff @(posedge spi_sck) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
			wr_ptr      <= wr_ptr + 1'b1;
		end

		if (do_pop)
			rd_ptr <= rd_ptr + 1'b1;

		case ({do_push, do_pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
		endcase
	end

	assign avail = (count != '0);
	assign head  = mem[rd_ptr];

	// pops come only from inside a transfer
	a_no_pop_idle: assert property (
		@(posedge spi_sck) SPI_SS_IO |-> !pop
	) else $error("byte_queue: pop while link is idle");

endmodule

`default_nettype wire

/* source/io_bridge_top.sv */
`timescale 1ns/1ns
`default_nettype none

module io_bridge_top (
	input  logic             spi_sck,
	input  logic             SPI_SS_IO,
	input  logic             spi_mosi,
	output logic             spi_miso,

	// core side of the keyboard and serial queues
	input  logic             kbd_push,
	input  io_pkg::io_byte_t kbd_push_data,
	input  logic             ser_push,
	input  io_pkg::io_byte_t ser_push_data,

	output logic             kbd_in_strobe,
	output io_pkg::io_byte_t kbd_in_data,
	output logic             ser_in_strobe,
	output io_pkg::io_byte_t ser_in_data,

	output logic [1:0]       buttons,
	output logic [1:0]       switches,
	output logic             scandoubler_disable,
	output logic             ypbpr,
	output io_pkg::joy_t     joy0,
	output io_pkg::joy_t     joy1,
	output io_pkg::joy_t     joy2,
	output io_pkg::joy_t     joy3
);

	io_link_if link0 ();

	io_pkg::cfg_t     cfg;
	logic             kbd_avail;
	logic             kbd_pop;
	io_pkg::io_byte_t kbd_head;
	logic             ser_avail;
	logic             ser_pop;
	io_pkg::io_byte_t ser_head;

	spi_frame frame0 (
		.spi_sck   (spi_sck),
		.SPI_SS_IO (SPI_SS_IO),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso),
		.link      (link0.frame)
	);

	io_cmd_decoder dec0 (
		.spi_sck       (spi_sck),
		.SPI_SS_IO     (SPI_SS_IO),
		.link          (link0.decoder),
		.kbd_avail     (kbd_avail),
		.kbd_head      (kbd_head),
		.kbd_pop       (kbd_pop),
		.ser_avail     (ser_avail),
		.ser_head      (ser_head),
		.ser_pop       (ser_pop),
		.kbd_in_strobe (kbd_in_strobe),
		.kbd_in_data   (kbd_in_data),
		.ser_in_strobe (ser_in_strobe),
		.ser_in_data   (ser_in_data),
		.cfg           (cfg),
		.joy0          (joy0),
		.joy1          (joy1),
		.joy2          (joy2),
		.joy3          (joy3)
	);

	byte_queue kbd_q0 (
		.spi_sck   (spi_sck),
		.SPI_SS_IO (SPI_SS_IO),
		.push      (kbd_push),
		.push_data (kbd_push_data),
		.pop       (kbd_pop),
		.avail     (kbd_avail),
		.head      (kbd_head)
	);

	byte_queue ser_q0 (
		.spi_sck   (spi_sck),
		.SPI_SS_IO (SPI_SS_IO),
		.push      (ser_push),
		.push_data (ser_push_data),
		.pop       (ser_pop),
		.avail     (ser_avail),
		.head      (ser_head)
	);

	// board configuration word
	assign buttons             = cfg[1:0];
	assign switches            = cfg[3:2];
	assign scandoubler_disable = cfg[4];
	assign ypbpr               = cfg[5];

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk
);

	// 4 ns period
	localparam int HALF_NS = 2;

	initial clk = 1'b0;

	always #HALF_NS clk = ~clk;

endmodule

`default_nettype wire

/* dv/tb_io_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_io_bridge;

	// one whitespace-separated word from the vector file
	typedef logic [127:0] token_t;

	localparam string VEC_FILE     = "dv/io_vectors.txt";
	localparam int    RESET_CYCLES = 16;

	logic             spi_sck;
	logic             SPI_SS_IO;
	logic             spi_mosi;
	logic             spi_miso;
	logic             kbd_push;
	io_pkg::io_byte_t kbd_push_data;
	logic             ser_push;
	io_pkg::io_byte_t ser_push_data;
	logic             kbd_in_strobe;
	io_pkg::io_byte_t kbd_in_data;
	logic             ser_in_strobe;
	io_pkg::io_byte_t ser_in_data;
	logic [1:0]       buttons;
	logic [1:0]       switches;
	logic             scandoubler_disable;
	logic             ypbpr;
	io_pkg::joy_t     joy0;
	io_pkg::joy_t     joy1;
	io_pkg::joy_t     joy2;
	io_pkg::joy_t     joy3;

	// parsed operations, payload bytes live in the pay_* queues
	logic [7:0]       op_kind [$];
	token_t           op_tag [$];
	io_pkg::io_byte_t op_val [$];
	int               op_cnt [$];
	int               op_base [$];
	io_pkg::io_byte_t pay_tx [$];
	io_pkg::io_byte_t pay_rx [$];

	int total_bytes = 0;
	int cycle_limit = 0;
	int cycles      = 0;
	int checks      = 0;
	int errors      = 0;
	int tests_run   = 0;

	bit     test_open   = 1'b0;
	token_t test_name;
	int     test_checks = 0;
	int     test_errors = 0;

	// strobe pulse counts, and the totals at the last check
	int kbd_pulses = 0;
	int ser_pulses = 0;
	int kbd_seen   = 0;
	int ser_seen   = 0;

	tb_clock clk0 (
		.clk (spi_sck)
	);

	io_bridge_top dut0 (
		.spi_sck             (spi_sck),
		.SPI_SS_IO           (SPI_SS_IO),
		.spi_mosi            (spi_mosi),
		.spi_miso            (spi_miso),
		.kbd_push            (kbd_push),
		.kbd_push_data       (kbd_push_data),
		.ser_push            (ser_push),
		.ser_push_data       (ser_push_data),
		.kbd_in_strobe       (kbd_in_strobe),
		.kbd_in_data         (kbd_in_data),
		.ser_in_strobe       (ser_in_strobe),
		.ser_in_data         (ser_in_data),
		.buttons             (buttons),
		.switches            (switches),
		.scandoubler_disable (scandoubler_disable),
		.ypbpr               (ypbpr),
		.joy0                (joy0),
		.joy1                (joy1),
		.joy2                (joy2),
		.joy3                (joy3)
	);

	always @(posedge kbd_in_strobe) kbd_pulses <= kbd_pulses + 1;
	always @(posedge ser_in_strobe) ser_pulses <= ser_pulses + 1;

	// watchdog, armed once the vectors are loaded
	always @(posedge spi_sck) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: the run did not end within %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic note_result(input bit ok);
		checks++;
		test_checks++;
		if (!ok) begin
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_byte(input string name, input io_pkg::io_byte_t got,
		input io_pkg::io_byte_t exp);
		if (got !== exp)
			$display("CHECK FAILED at %0t ns: %0s got %h expected %h", $time, name, got, exp);
		note_result(got === exp);
	endtask

	task automatic check_joy(input string name, input io_pkg::joy_t got,
		input io_pkg::joy_t exp);
		if (got !== exp)
			$display("CHECK FAILED at %0t ns: %0s got %h expected %h", $time, name, got, exp);
		note_result(got === exp);
	endtask

	task automatic check_cfg(input string name, input io_pkg::cfg_t got,
		input io_pkg::cfg_t exp);
		if (got !== exp)
			$display("CHECK FAILED at %0t ns: %0s got %h expected %h", $time, name, got, exp);
		note_result(got === exp);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			$display("CHECK FAILED at %0t ns: %0s got %b expected %b", $time, name, got, exp);
		note_result(got === exp);
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			$display("CHECK FAILED at %0t ns: %0s got %0d expected %0d", $time, name, got, exp);
		note_result(got == exp);
	endtask

	task automatic finish_test();
		if (test_open) begin
			$display("test %0s: %0d checks, %0d errors, %0s", test_name, test_checks,
				test_errors, (test_errors == 0) ? "ok" : "FAILED");
			tests_run++;
		end
		test_open = 1'b0;
	endtask

	task automatic start_test(input token_t name);
		finish_test();
		test_open   = 1'b1;
		test_name   = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic add_op(input logic [7:0] kind, input token_t tag,
		input io_pkg::io_byte_t val, input int cnt, input int base);
		op_kind.push_back(kind);
		op_tag.push_back(tag);
		op_val.push_back(val);
		op_cnt.push_back(cnt);
		op_base.push_back(base);
	endtask

	task automatic load_vectors(output bit ok);
		int fd;
		int ch;
		int k;
		int n;
		token_t tok;
		token_t name;
		io_pkg::io_byte_t a;
		io_pkg::io_byte_t b;
		ok = 1'b1;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the vector file %0s", VEC_FILE);
			ok = 1'b0;
			return;
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			n = 0;
			case (tok[7:0])
				"#": begin
					// rest of the line is a comment, 10 is newline
					ch = 0;
					while (ch != 10 && ch != -1)
						ch = $fgetc(fd);
				end
				"N": begin
					if ($fscanf(fd, "%s", name) != 1)
						ok = 1'b0;
					add_op("N", name, '0, 0, 0);
				end
				"P": begin
					if ($fscanf(fd, "%s %h", name, a) != 2)
						ok = 1'b0;
					add_op("P", name, a, 0, 0);
				end
				"T": begin
					if ($fscanf(fd, "%h %h", a, n) != 2)
						ok = 1'b0;
					add_op("T", '0, a, n, pay_tx.size());
					for (k = 0; k < n && ok; k++) begin
						if ($fscanf(fd, "%h %h", a, b) != 2)
							ok = 1'b0;
						pay_tx.push_back(a);
						pay_rx.push_back(b);
					end
					total_bytes += 1 + n;
				end
				"B": begin
					if ($fscanf(fd, "%h", n) != 1)
						ok = 1'b0;
					add_op("B", '0, '0, n, 0);
					total_bytes += (n + 7) / 8;
				end
				"S": add_op("S", '0, '0, 0, 0);
				"E": begin
					if ($fscanf(fd, "%s %h", name, a) != 2)
						ok = 1'b0;
					add_op("E", name, a, 0, 0);
				end
				default: ok = 1'b0;
			endcase
		end
		$fclose(fd);
		if (!ok)
			$display("the vector file has a line that cannot be read");
		if (op_kind.size() == 0) begin
			$display("the vector file holds no operations");
			ok = 1'b0;
		end
	endtask

	// one bit per cycle, msb first; returns the byte seen on miso
	task automatic shift_byte(input io_pkg::io_byte_t tx, output io_pkg::io_byte_t rx);
		int i;
		rx = '0;
		for (i = 7; i >= 0; i--) begin
			spi_mosi = tx[i];
			@(posedge spi_sck);
			rx[i] = spi_miso;
			@(negedge spi_sck);
		end
	endtask

	task automatic run_transfer(input io_pkg::io_byte_t cmd, input int cnt, input int base);
		io_pkg::io_byte_t got;
		int k;
		SPI_SS_IO = 1'b0;
		shift_byte(cmd, got);
		check_byte("spi_miso command slot", got, io_pkg::CORE_TYPE);
		for (k = 0; k < cnt; k++) begin
			shift_byte(pay_tx[base + k], got);
			check_byte($sformatf("spi_miso payload %0d", k), got, pay_rx[base + k]);
		end
	endtask

	// part of a byte with the link still selected
	task automatic send_bits(input int n);
		repeat (n) begin
			spi_mosi = 1'b0;
			@(posedge spi_sck);
			@(negedge spi_sck);
		end
	endtask

	task automatic end_transfer();
		SPI_SS_IO = 1'b1;
		spi_mosi  = 1'b0;
		@(negedge spi_sck);
	endtask

	task automatic push_byte(input token_t which, input io_pkg::io_byte_t data);
		if (which == token_t'("kbd")) begin
			kbd_push      = 1'b1;
			kbd_push_data = data;
		end else if (which == token_t'("ser")) begin
			ser_push      = 1'b1;
			ser_push_data = data;
		end else begin
			$display("the vector file pushes into an unknown queue");
			note_result(1'b0);
		end
		@(negedge spi_sck);
		kbd_push = 1'b0;
		ser_push = 1'b0;
	endtask

	task automatic check_expect(input token_t tag, input io_pkg::io_byte_t val);
		io_pkg::cfg_t cfg_now;
		cfg_now = {ypbpr, scandoubler_disable, switches, buttons};
		case (tag)
			token_t'("kbd_data"):    check_byte("kbd_in_data", kbd_in_data, val);
			token_t'("ser_data"):    check_byte("ser_in_data", ser_in_data, val);
			token_t'("kbd_strobe"):  check_bit("kbd_in_strobe", kbd_in_strobe, val[0]);
			token_t'("ser_strobe"):  check_bit("ser_in_strobe", ser_in_strobe, val[0]);
			token_t'("cfg"):         check_cfg("cfg outputs", cfg_now, val[5:0]);
			token_t'("ypbpr"):       check_bit("ypbpr", ypbpr, val[0]);
			token_t'("scandoubler"): check_bit("scandoubler_disable", scandoubler_disable, val[0]);
			token_t'("joy0"):        check_joy("joy0", joy0, val[5:0]);
			token_t'("joy1"):        check_joy("joy1", joy1, val[5:0]);
			token_t'("joy2"):        check_joy("joy2", joy2, val[5:0]);
			token_t'("joy3"):        check_joy("joy3", joy3, val[5:0]);
			token_t'("kbd_pulses"): begin
				check_count("kbd_in_strobe pulses", kbd_pulses - kbd_seen, int'(val));
				kbd_seen = kbd_pulses;
			end
			token_t'("ser_pulses"): begin
				check_count("ser_in_strobe pulses", ser_pulses - ser_seen, int'(val));
				ser_seen = ser_pulses;
			end
			default: begin
				$display("the vector file expects a value of an unknown output");
				note_result(1'b0);
			end
		endcase
	endtask

	task automatic run_op(input int i);
		case (op_kind[i])
			"N": start_test(op_tag[i]);
			"P": push_byte(op_tag[i], op_val[i]);
			"T": run_transfer(op_val[i], op_cnt[i], op_base[i]);
			"B": send_bits(op_cnt[i]);
			"S": end_transfer();
			"E": check_expect(op_tag[i], op_val[i]);
			default: ;
		endcase
	endtask

	initial begin
		bit loaded;
		int i;
		SPI_SS_IO     = 1'b1;
		spi_mosi      = 1'b0;
		kbd_push      = 1'b0;
		kbd_push_data = '0;
		ser_push      = 1'b0;
		ser_push_data = '0;

		load_vectors(loaded);
		if (loaded) begin
			cycle_limit = RESET_CYCLES + 12 * total_bytes + 200;
			repeat (RESET_CYCLES) @(negedge spi_sck);
			for (i = 0; i < op_kind.size(); i++)
				run_op(i);
			finish_test();
		end else begin
			errors++;
		end

		if (checks == 0) begin
			$display("no checks were run");
			errors++;
		end
		$display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/io_vectors.txt */
# N test name | P kbd|ser byte | T cmd count {mosi miso}... | B bits | S | E output value
# numbers in hex; T checks the command slot itself, each payload pair gives the expected miso
N cfg_word
T 01 1 ed 00
E cfg 2d
E ypbpr 1
E scandoubler 0
S
E cfg 2d
N joysticks
T 10 1 ff 00
S
T 11 1 15 00
S
T 12 1 6a 00
S
T 13 1 c7 00
S
E joy0 3f
E joy1 15
E joy2 2a
E joy3 07
E cfg 2d
N kbd_in_single
T 02 1 5a 00
E kbd_strobe 1
E kbd_data 5a
B 2
E kbd_strobe 0
E kbd_data 5a
S
E kbd_pulses 1
N kbd_in_multi
T 02 3 11 00 22 00 33 00
E kbd_data 33
E kbd_strobe 1
S
E kbd_strobe 0
E kbd_pulses 3
N ser_in
T 04 2 41 00 42 00
E ser_strobe 1
E ser_data 42
S
E ser_strobe 0
E ser_pulses 2
E kbd_data 33
N kbd_out
P kbd 61
P kbd 62
P ser 31
T 03 4 00 01 00 61 00 01 00 62
S
T 03 1 00 00
S
N ser_out_full
P ser 32
P ser 33
P ser 34
# fifth byte, dropped by the full queue
P ser 35
T 05 9 00 01 00 31 00 01 00 32 00 01 00 33 00 01 00 34 00 00
S
T 03 1 00 00
S
N abort_mid_byte
T 02 1 77 00
B 1
E kbd_strobe 1
S
E kbd_strobe 0
E ser_strobe 0
E kbd_data 77
E kbd_pulses 1
T 04 1 88 00
B 1
E ser_strobe 1
S
E ser_strobe 0
E kbd_strobe 0
E ser_data 88
E ser_pulses 1
T 01 1 00 00
S
E cfg 00

/* files.f */
source/io_pkg.sv
source/io_link_if.sv
source/spi_frame.sv
source/io_cmd_decoder.sv
source/byte_queue.sv
source/io_bridge_top.sv
dv/tb_clock.sv
dv/tb_io_bridge.sv

/* run.sh */
#!/bin/sh
# build and run the io bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 --assert -Wno-fatal --top-module tb_io_bridge \
	-f files.f -o tb_io_bridge
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_io_bridge > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	exit 1
fi
exit 0
